// ==== a2bus_config.svh ====
`ifndef A2BUS_CONFIG_SVH
`define A2BUS_CONFIG_SVH

// Bus widths
`define A2_ADDR_W       16
`define A2_RAM_ADDR_W   16
`define A2_DATA_W       8

// Slot or device number inside a select group
`define A2_SLOT_W       3

// Width of the decoded target code
`define A2_SEL_W        4

// ----------------------------------------
// Address constants
// ----------------------------------------

`define A2_IO_PAGE      8'hC0       // Built-in I/O and soft switches
`define A2_C3_PAGE      8'hC3       // Slot 3 firmware page
`define A2_CXROM_END    16'hCFFF    // Releases the C800 space

`endif

// ==== a2bus_pkg.sv ====
`include "a2bus_config.svh"

package a2bus_pkg;

    // One address word, seen flat or as a C0xx I/O location
    typedef union packed {
        logic [`A2_ADDR_W-1:0] raw;
        struct packed {
            logic [7:0] page;   // High byte
            logic [3:0] group;  // Sixteen-byte device group
            logic [2:0] index;  // Switch number
            logic       state;  // New switch value
        } io;
    } a2_addr_u;

    // Target of a decoded access
    typedef enum logic [`A2_SEL_W-1:0] {
        sel_ram,        // 0000-BFFF
        sel_rom,        // Internal or slot ROM, D000-FFFF
        sel_kbd,        // C00x
        sel_c01x,       // Status reads
        sel_tape,       // C02x
        sel_spkr,       // C03x
        sel_strobe,     // C04x
        sel_softsw,     // C05x
        sel_game,       // C06x
        sel_pdl,        // C07x
        sel_lcctl,      // C08x language card
        sel_devsel,     // C090-C0FF
        sel_iosel,      // C100-C7FF
        sel_iostrb,     // C800-CFFF
        sel_none
    } a2_sel_e;

endpackage

// ==== a2bus_decode.sv ====
`include "a2bus_config.svh"

module a2bus_decode (
    input  logic                    CLK_14M,
    input  logic                    reset,
    input  logic                    bus_strobe,
    input  logic [`A2_ADDR_W-1:0]   addr,
    input  logic                    we,
    input  logic [`A2_DATA_W-1:0]   wdata,
    input  logic                    cxrom,
    input  logic                    c3rom,
    input  logic                    c8rom,
    output logic                    d_valid,
    output a2bus_pkg::a2_addr_u     d_addr,
    output logic                    d_we,
    output logic [`A2_DATA_W-1:0]   d_wdata,
    output a2bus_pkg::a2_sel_e      d_sel,
    output logic [`A2_SLOT_W-1:0]   d_slot
);
    import a2bus_pkg::*;

    a2_addr_u               a;      // Incoming address, I/O view used below
    a2_sel_e                sel;
    logic [`A2_SLOT_W-1:0]  slot;

    assign a = addr;

    // ----------------------------------------
    // Region decode
    // ----------------------------------------

    always_comb
    begin
        sel  = sel_none;
        slot = '0;
        if (a.io.page < `A2_IO_PAGE)
            sel = sel_ram;                      // 0000-BFFF
        else if (a.io.page[7:4] != 4'hC)
            sel = sel_rom;                      // D000-FFFF
        else if (a.io.page == `A2_IO_PAGE)
        begin
            case (a.io.group)
                4'h0: sel = sel_kbd;
                4'h1: sel = sel_c01x;
                4'h2: sel = sel_tape;
                4'h3: sel = sel_spkr;
                4'h4: sel = sel_strobe;
                4'h5: sel = sel_softsw;
                4'h6: sel = sel_game;
                4'h7: sel = sel_pdl;
                4'h8: sel = sel_lcctl;
                default:
                begin
                    sel  = sel_devsel;          // C090-C0FF, slots 1-7
                    slot = a.io.group[2:0];
                end
            endcase
        end
        else if (a.io.page[3])
        begin
            // Shared expansion ROM space
            if (cxrom || c8rom)
                sel = sel_rom;
            else
                sel = sel_iostrb;
        end
        else if (cxrom || (a.io.page == `A2_C3_PAGE && !c3rom))
            sel = sel_rom;                      // Internal slot firmware
        else
        begin
            sel  = sel_iosel;
            slot = a.io.page[2:0];
        end
    end

    // ----------------------------------------
    // Stage register
    // ----------------------------------------

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
            d_valid <= 1'b0;
        else
            d_valid <= bus_strobe;
    end

    always_ff @(posedge CLK_14M)
    begin
        if (bus_strobe)
        begin
            d_addr  <= a;
            d_we    <= we;
            d_wdata <= wdata;
            d_sel   <= sel;
            d_slot  <= slot;
        end
    end

endmodule

// ==== a2bus_switches.sv ====
`include "a2bus_config.svh"

module a2bus_switches (
    input  logic                    CLK_14M,
    input  logic                    reset,
    input  logic                    d_valid,
    input  a2bus_pkg::a2_addr_u     d_addr,
    input  logic                    d_we,
    input  logic [`A2_DATA_W-1:0]   d_wdata,
    input  a2bus_pkg::a2_sel_e      d_sel,
    input  logic [`A2_SLOT_W-1:0]   d_slot,
    input  logic                    akd,
    output logic                    s_valid,
    output a2bus_pkg::a2_addr_u     s_addr,
    output logic                    s_we,
    output logic [`A2_DATA_W-1:0]   s_wdata,
    output a2bus_pkg::a2_sel_e      s_sel,
    output logic [`A2_SLOT_W-1:0]   s_slot,
    output logic                    s_status,
    output logic                    s_ramrd,
    output logic                    s_ramwrt,
    output logic                    s_store80,
    output logic                    s_page2,
    output logic                    s_hires,
    output logic                    s_altzp,
    output logic                    s_hram_read,
    output logic                    s_hram_wr_en,
    output logic                    s_bank1,
    output logic                    cxrom,
    output logic                    c3rom,
    output logic                    c8rom,
    output logic [3:0]              an,
    output logic                    col80,
    output logic                    altchar
);
    import a2bus_pkg::*;

    logic [7:0]     sw;             // C05x: text, mixed, page2, hires, an0-an3
    logic           col80_r;
    logic           altchar_r;
    logic           hram_pre_wr;    // Last LC access was an odd read
    logic [15:0]    status_vec;

    assign s_page2 = sw[2];
    assign s_hires = sw[3];

    // C010-C01F status bits, VBL reads as zero
    assign status_vec = {col80_r, altchar_r, sw[3], sw[2], sw[1], sw[0], 1'b0, s_store80,
                         c3rom, s_altzp, cxrom, s_ramwrt, s_ramrd, s_hram_read, ~s_bank1,
                         akd};

    // ----------------------------------------
    // Switch state
    // ----------------------------------------

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            sw           <= '0;
            s_store80    <= 1'b0;
            s_ramrd      <= 1'b0;
            s_ramwrt     <= 1'b0;
            cxrom        <= 1'b0;
            s_altzp      <= 1'b0;
            c3rom        <= 1'b0;
            col80_r      <= 1'b0;
            altchar_r    <= 1'b0;
            c8rom        <= 1'b0;
            hram_pre_wr  <= 1'b0;
            s_hram_read  <= 1'b0;
            s_hram_wr_en <= 1'b0;
            s_bank1      <= 1'b0;   // Bank 2
        end
        else if (d_valid)
        begin
            if (d_sel == sel_softsw)
                sw[d_addr.io.index] <= d_addr.io.state;

            // //e switches, writes only
            if (d_sel == sel_kbd && d_we)
            begin
                case (d_addr.io.index)
                    3'd0: s_store80 <= d_addr.io.state;
                    3'd1: s_ramrd   <= d_addr.io.state;
                    3'd2: s_ramwrt  <= d_addr.io.state;
                    3'd3: cxrom     <= d_addr.io.state;
                    3'd4: s_altzp   <= d_addr.io.state;
                    3'd5: c3rom     <= d_addr.io.state;
                    3'd6: col80_r   <= d_addr.io.state;
                    default: altchar_r <= d_addr.io.state;
                endcase
            end

            if (d_addr.io.page == `A2_C3_PAGE && !c3rom)
                c8rom <= 1'b1;
            else if (d_addr.raw == `A2_CXROM_END)
                c8rom <= 1'b0;

            // Language card, write enable needs two odd reads in a row
            if (d_sel == sel_lcctl)
            begin
                s_bank1     <= d_addr.raw[3];
                s_hram_read <= d_addr.raw[0] ~^ d_addr.raw[1];
                hram_pre_wr <= d_addr.raw[0] & ~d_we;
                if (hram_pre_wr && !d_we && d_addr.raw[0])
                    s_hram_wr_en <= 1'b1;
                else if (!d_addr.raw[0])
                    s_hram_wr_en <= 1'b0;   // Any even access
            end
        end
    end

    // Display outputs trail by one edge to line up with the response
    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
            {an, col80, altchar} <= '0;
        else
            {an, col80, altchar} <= {sw[7:4], col80_r, altchar_r};
    end

    // ----------------------------------------
    // Forwarding to the mapper
    // ----------------------------------------

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
            s_valid <= 1'b0;
        else
            s_valid <= d_valid;
    end

    always_ff @(posedge CLK_14M)
    begin
        if (d_valid)
        begin
            s_addr  <= d_addr;
            s_we    <= d_we;
            s_wdata <= d_wdata;
            s_sel   <= d_sel;
            s_slot  <= d_slot;
            if (d_sel == sel_c01x && !d_we)
                s_status <= status_vec[d_addr.raw[3:0]];    // State before this access
        end
    end

endmodule

// ==== a2bus_mapper.sv ====
`include "a2bus_config.svh"

module a2bus_mapper (
    input  logic                        CLK_14M,
    input  logic                        reset,
    input  logic                        s_valid,
    input  a2bus_pkg::a2_addr_u         s_addr,
    input  logic                        s_we,
    input  logic [`A2_DATA_W-1:0]       s_wdata,
    input  a2bus_pkg::a2_sel_e          s_sel,
    input  logic [`A2_SLOT_W-1:0]       s_slot,
    input  logic                        s_status,
    input  logic                        s_ramrd,
    input  logic                        s_ramwrt,
    input  logic                        s_store80,
    input  logic                        s_page2,
    input  logic                        s_hires,
    input  logic                        s_altzp,
    input  logic                        s_hram_read,
    input  logic                        s_hram_wr_en,
    input  logic                        s_bank1,
    input  logic [2*`A2_DATA_W-1:0]     ram_do,     // Low byte main, high byte aux
    input  logic [`A2_DATA_W-1:0]       k,
    input  logic [7:0]                  gameport,
    input  logic [`A2_DATA_W-1:0]       pd,
    output logic                        rsp_valid,
    output logic [`A2_DATA_W-1:0]       rdata,
    output logic [`A2_RAM_ADDR_W-1:0]   ram_addr,
    output logic                        ram_we,
    output logic                        aux,
    output logic                        rom_cs,
    output logic                        speaker,
    output logic                        read_key,
    output logic                        pdl_strobe,
    output logic                        stb,
    output logic                        io_strobe,
    output logic [7:0]                  io_select,
    output logic [7:0]                  device_select
);
    import a2bus_pkg::*;

    logic                       hram_area;  // D000-FFFF
    logic                       hram_hit;
    logic                       dxxx;
    logic                       rw_aux;
    logic                       aux_c;
    logic [`A2_DATA_W-1:0]      ram_byte;
    logic [`A2_DATA_W-1:0]      rdata_c;
    logic [`A2_RAM_ADDR_W-1:0]  ram_addr_c;
    logic [7:0]                 slot_onehot;

    assign hram_area   = s_addr.io.page[7:6] == 2'b11 && s_addr.io.page[5:4] != 2'b00;
    assign hram_hit    = hram_area && s_hram_read;
    assign dxxx        = s_addr.io.page[7:4] == 4'hD;
    assign rw_aux      = s_we ? s_ramwrt : s_ramrd;
    assign ram_byte    = aux_c ? ram_do[15:8] : ram_do[7:0];
    assign slot_onehot = 8'd1 << s_slot;

    // Bank 1 of Dxxx folds onto the C000 block of RAM
    assign ram_addr_c = {s_addr.raw[15:13], s_addr.raw[12] & ~(s_bank1 & dxxx),
                         s_addr.raw[11:0]};

    // ----------------------------------------
    // Main or aux selection
    // ----------------------------------------

    always_comb
    begin
        if (s_addr.io.page[7:1] == 7'h00 || s_addr.io.page[7:6] == 2'b11)
            aux_c = s_altzp;                    // Pages 00-01, C0-FF
        else if (s_addr.io.page[7:2] == 6'h01 && s_store80)
            aux_c = s_page2;                    // Text page 1
        else if (s_addr.io.page[7:5] == 3'b001 && s_store80 && s_hires)
            aux_c = s_page2;                    // Hires page 1
        else
            aux_c = rw_aux;
    end

    // Byte returned to the processor
    always_comb
    begin
        if (s_sel == sel_ram || hram_hit)
            rdata_c = ram_byte;
        else if (s_sel == sel_kbd)
            rdata_c = k;
        else if (s_sel == sel_c01x)
            rdata_c = {s_status, k[6:0]};
        else if (s_sel == sel_game)
            rdata_c = {gameport[s_addr.raw[2:0]], 7'b0};
        else if (s_we)
            rdata_c = s_wdata;                  // Bus carries the written byte
        else
            rdata_c = pd;                       // Floating bus and peripherals
    end

    // ----------------------------------------
    // Response registers
    // ----------------------------------------

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            rsp_valid     <= 1'b0;
            ram_we        <= 1'b0;
            aux           <= 1'b0;
            rom_cs        <= 1'b0;
            speaker       <= 1'b0;
            read_key      <= 1'b0;
            pdl_strobe    <= 1'b0;
            stb           <= 1'b0;
            io_strobe     <= 1'b0;
            io_select     <= '0;
            device_select <= '0;
        end
        else
        begin
            rsp_valid  <= s_valid;
            ram_we     <= s_valid && s_we && (s_sel == sel_ram || (hram_area && s_hram_wr_en));
            rom_cs     <= s_valid && s_sel == sel_rom && !hram_hit;
            read_key   <= s_valid && s_sel == sel_c01x && (s_we || s_addr.raw[3:0] == 4'h0);
            pdl_strobe <= s_valid && s_sel == sel_pdl;
            stb        <= s_valid && s_sel == sel_strobe;
            io_strobe  <= s_valid && s_sel == sel_iostrb;
            io_select     <= (s_valid && s_sel == sel_iosel) ? slot_onehot : 8'h00;
            device_select <= (s_valid && s_sel == sel_devsel) ? slot_onehot : 8'h00;
            if (s_valid)
                aux <= aux_c;                   // Holds between accesses
            if (s_valid && s_sel == sel_spkr)
                speaker <= ~speaker;
        end
    end

    always_ff @(posedge CLK_14M)
    begin
        if (s_valid)
        begin
            rdata    <= rdata_c;
            ram_addr <= ram_addr_c;
        end
    end

endmodule

// ==== a2bus_top.sv ====
`include "a2bus_config.svh"

module a2bus_top (
    input  logic                        CLK_14M,
    input  logic                        reset,
    input  logic                        bus_strobe,
    input  logic [`A2_ADDR_W-1:0]       addr,
    input  logic                        we,
    input  logic [`A2_DATA_W-1:0]       wdata,
    input  logic [2*`A2_DATA_W-1:0]     ram_do,
    input  logic [`A2_DATA_W-1:0]       k,
    input  logic                        akd,        // Any key down
    input  logic [7:0]                  gameport,
    input  logic [`A2_DATA_W-1:0]       pd,
    output logic                        rsp_valid,
    output logic [`A2_DATA_W-1:0]       rdata,
    output logic [`A2_RAM_ADDR_W-1:0]   ram_addr,
    output logic                        ram_we,
    output logic                        aux,
    output logic                        rom_cs,
    output logic                        speaker,
    output logic                        read_key,
    output logic                        pdl_strobe,
    output logic                        stb,
    output logic                        io_strobe,
    output logic [7:0]                  io_select,
    output logic [7:0]                  device_select,
    output logic [3:0]                  an,
    output logic                        col80,
    output logic                        altchar
);
    import a2bus_pkg::*;

    // Decode to switches
    logic                   d_valid;
    a2_addr_u               d_addr;
    logic                   d_we;
    logic [`A2_DATA_W-1:0]  d_wdata;
    a2_sel_e                d_sel;
    logic [`A2_SLOT_W-1:0]  d_slot;

    // Switches to mapper
    logic                   s_valid;
    a2_addr_u               s_addr;
    logic                   s_we;
    logic [`A2_DATA_W-1:0]  s_wdata;
    a2_sel_e                s_sel;
    logic [`A2_SLOT_W-1:0]  s_slot;
    logic                   s_status;
    logic                   s_ramrd;
    logic                   s_ramwrt;
    logic                   s_store80;
    logic                   s_page2;
    logic                   s_hires;
    logic                   s_altzp;
    logic                   s_hram_read;
    logic                   s_hram_wr_en;
    logic                   s_bank1;

    // Committed ROM switches back to the decoder
    logic                   cxrom;
    logic                   c3rom;
    logic                   c8rom;

    a2bus_decode u_decode (.*);

    a2bus_switches u_switches (.*);

    a2bus_mapper u_mapper (.*);

endmodule

// ==== a2bus_assert.sv ====
module a2bus_assert (
    input  logic        CLK_14M,
    input  logic        reset,
    input  logic        bus_strobe,
    input  logic        rsp_valid,
    input  logic        ram_we,
    input  logic [7:0]  io_select
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // One response per strobe, three edges on
    // ----------------------------------------

    rsp_has_strobe: assert property (@(posedge CLK_14M) disable iff (reset)
        rsp_valid |-> $past(bus_strobe, 3))
        else $error("rsp_valid without a strobe three edges earlier");

    strobe_gets_rsp: assert property (@(posedge CLK_14M) disable iff (reset)
        bus_strobe |-> ##3 rsp_valid)
        else $error("strobe not answered three edges later");

    ram_we_in_rsp: assert property (@(posedge CLK_14M) disable iff (reset)
        ram_we |-> rsp_valid)
        else $error("ram_we outside a response cycle");

    // Selects
    io_select_onehot: assert property (@(posedge CLK_14M) disable iff (reset)
        $onehot0(io_select))
        else $error("io_select has more than one bit set");

endmodule

// ==== tb_a2bus.sv ====
`include "a2bus_config.svh"

module tb_a2bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int RSP_WAIT   = 8;      // Cycles allowed per response
    localparam int MAX_ACCESS = 80;     // Upper bound over all tests
    localparam int RUN_LIMIT  = (4 + MAX_ACCESS * (RSP_WAIT + 2)) * CLK_PERIOD;

    logic                       CLK_14M = 1'b0;
    logic                       reset;
    logic                       bus_strobe;
    logic [`A2_ADDR_W-1:0]      addr;
    logic                       we;
    logic [`A2_DATA_W-1:0]      wdata;
    logic [2*`A2_DATA_W-1:0]    ram_do;
    logic [`A2_DATA_W-1:0]      k;
    logic                       akd;
    logic [7:0]                 gameport;
    logic [`A2_DATA_W-1:0]      pd;
    logic                       rsp_valid;
    logic [`A2_DATA_W-1:0]      rdata;
    logic [`A2_RAM_ADDR_W-1:0]  ram_addr;
    logic                       ram_we;
    logic                       aux;
    logic                       rom_cs;
    logic                       speaker;
    logic                       read_key;
    logic                       pdl_strobe;
    logic                       stb;
    logic                       io_strobe;
    logic [7:0]                 io_select;
    logic [7:0]                 device_select;
    logic [3:0]                 an;
    logic                       col80;
    logic                       altchar;

    int                         errors = 0;
    int                         checks = 0;
    int                         mark;
    logic [31:0]                lcg_state = 32'h1faa;
    logic [2*`A2_DATA_W-1:0]    ram_do_v = '0;  // Applied with the next strobe
    logic [`A2_DATA_W-1:0]      k_v = '0;
    logic [`A2_DATA_W-1:0]      pd_v = '0;
    logic [7:0]                 gp_v = '0;

    a2bus_top UUT (.*);

    bind a2bus_top a2bus_assert u_assert (.CLK_14M(CLK_14M), .reset(reset),
        .bus_strobe(bus_strobe), .rsp_valid(rsp_valid), .ram_we(ram_we),
        .io_select(io_select));

    always #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic byte_eq(input string name, input logic [`A2_DATA_W-1:0] got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic ram_addr_eq(input string name, input logic [`A2_RAM_ADDR_W-1:0] got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic flag_eq(input string name, input logic got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic mask_eq(input string name, input logic [7:0] got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // One strobed access, returns in the response cycle
    task automatic bus_access(input logic [15:0] a, input logic w, input logic [7:0] d);
        int n;
        @(posedge CLK_14M);
        bus_strobe <= 1'b1;
        addr       <= a;
        we         <= w;
        wdata      <= d;
        ram_do     <= ram_do_v;
        k          <= k_v;
        pd         <= pd_v;
        gameport   <= gp_v;
        @(posedge CLK_14M);
        bus_strobe <= 1'b0;
        n = 0;
        do
        begin
            @(negedge CLK_14M);
            n++;
        end
        while (!rsp_valid && n < RSP_WAIT);
        if (!rsp_valid)
        begin
            errors++;
            $display("%0t ns: access to %h got no response", $time, a);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%-18s %0d errors", name, errors - errs_before);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic region_decode();
        logic [15:0] a;
        repeat (8)
        begin
            a        = 16'((next_random() >> 8) % 32'hC000);   // 0000-BFFF
            ram_do_v = 16'(next_random() >> 16);
            bus_access(a, 1'b0, 8'h00);
            byte_eq("rdata", rdata, ram_do_v[7:0]);
            ram_addr_eq("ram_addr", ram_addr, a);
            flag_eq("ram_we", ram_we, 1'b0);
            flag_eq("aux", aux, 1'b0);
        end
        repeat (4)
        begin
            a    = 16'hD000 + 16'((next_random() >> 8) % 32'h3000);
            pd_v = 8'(next_random() >> 24);
            bus_access(a, 1'b0, 8'h00);
            flag_eq("rom_cs", rom_cs, 1'b1);
            byte_eq("rdata", rdata, pd_v);
        end
    endtask

    task automatic aux_switches();
        ram_do_v = 16'hA55A;
        bus_access(16'hC003, 1'b1, 8'h00);     // RAMRD on
        bus_access(16'h2000, 1'b0, 8'h00);
        byte_eq("rdata", rdata, 8'hA5);
        flag_eq("aux", aux, 1'b1);
        bus_access(16'hC002, 1'b1, 8'h00);
        bus_access(16'h2000, 1'b0, 8'h00);
        byte_eq("rdata", rdata, 8'h5A);
        bus_access(16'hC009, 1'b1, 8'h00);     // ALTZP on
        bus_access(16'h0000, 1'b0, 8'h00);
        flag_eq("aux", aux, 1'b1);
        byte_eq("rdata", rdata, 8'hA5);
        k_v = 8'(next_random() >> 24);
        bus_access(16'hC003, 1'b1, 8'h00);
        bus_access(16'hC013, 1'b0, 8'h00);
        byte_eq("rdata", rdata, {1'b1, k_v[6:0]});
        bus_access(16'hC016, 1'b0, 8'h00);
        byte_eq("rdata", rdata, {1'b1, k_v[6:0]});
        bus_access(16'hC002, 1'b1, 8'h00);
        bus_access(16'hC008, 1'b1, 8'h00);
        bus_access(16'hC013, 1'b0, 8'h00);
        byte_eq("rdata", rdata, {1'b0, k_v[6:0]});
        bus_access(16'hC016, 1'b0, 8'h00);
        byte_eq("rdata", rdata, {1'b0, k_v[6:0]});
    endtask

    task automatic display_switches();
        logic [15:0] a;
        logic [3:0]  exp_an;
        exp_an = 4'h0;
        repeat (8)
        begin
            a = 16'hC058 + 16'(next_random() >> 29);           // Annunciator switches
            exp_an[a[3:1] - 3'd4] = a[0];
            bus_access(a, 1'b0, 8'h00);
            mask_eq("an", {4'h0, an}, {4'h0, exp_an});
        end
        bus_access(16'hC00D, 1'b1, 8'h00);     // 80COL on
        bus_access(16'hC00F, 1'b1, 8'h00);     // ALTCHAR on
        flag_eq("col80", col80, 1'b1);
        flag_eq("altchar", altchar, 1'b1);
        bus_access(16'hC00C, 1'b1, 8'h00);
        bus_access(16'hC00E, 1'b1, 8'h00);
        flag_eq("col80", col80, 1'b0);
        flag_eq("altchar", altchar, 1'b0);
        ram_do_v = 16'h3CC3;
        bus_access(16'hC001, 1'b1, 8'h00);     // 80STORE
        bus_access(16'hC055, 1'b0, 8'h00);     // PAGE2
        bus_access(16'h0400 + 16'((next_random() >> 8) % 32'h400), 1'b0, 8'h00);
        flag_eq("aux", aux, 1'b1);
        byte_eq("rdata", rdata, 8'h3C);
        bus_access(16'hC054, 1'b0, 8'h00);
        bus_access(16'h0400, 1'b0, 8'h00);
        flag_eq("aux", aux, 1'b0);
        byte_eq("rdata", rdata, 8'hC3);
        bus_access(16'hC000, 1'b1, 8'h00);
    endtask

    task automatic language_card();
        ram_do_v = 16'h7E81;
        bus_access(16'hC08B, 1'b0, 8'h00);
        bus_access(16'hC08B, 1'b0, 8'h00);     // Second odd read arms writes
        bus_access(16'hD123, 1'b1, 8'h42);
        ram_addr_eq("ram_addr", ram_addr, 16'hC123);
        flag_eq("ram_we", ram_we, 1'b1);
        bus_access(16'hD123, 1'b0, 8'h00);
        byte_eq("rdata", rdata, 8'h81);
        flag_eq("rom_cs", rom_cs, 1'b0);
        bus_access(16'hC08A, 1'b0, 8'h00);
        bus_access(16'hD123, 1'b1, 8'h42);
        flag_eq("ram_we", ram_we, 1'b0);
        bus_access(16'hC082, 1'b0, 8'h00);     // ROM reads, bank 2
        bus_access(16'hE000, 1'b0, 8'h00);
        flag_eq("rom_cs", rom_cs, 1'b1);
    endtask

    task automatic slot_space();
        bus_access(16'hC500, 1'b0, 8'h00);
        mask_eq("io_select", io_select, 8'h01 << 5);
        bus_access(16'hC0A0, 1'b0, 8'h00);
        mask_eq("device_select", device_select, 8'h01 << (4'hA - 4'h8));
        bus_access(16'hC300, 1'b0, 8'h00);     // Internal slot 3 ROM, sets C8ROM
        flag_eq("rom_cs", rom_cs, 1'b1);
        bus_access(16'hC800, 1'b0, 8'h00);
        flag_eq("rom_cs", rom_cs, 1'b1);
        flag_eq("io_strobe", io_strobe, 1'b0);
        bus_access(16'hCFFF, 1'b0, 8'h00);
        bus_access(16'hC800, 1'b0, 8'h00);
        flag_eq("io_strobe", io_strobe, 1'b1);
        flag_eq("rom_cs", rom_cs, 1'b0);
        bus_access(16'hC030, 1'b0, 8'h00);     // Speaker low since reset
        flag_eq("speaker", speaker, 1'b1);
        bus_access(16'hC030, 1'b1, 8'h00);
        flag_eq("speaker", speaker, 1'b0);
        bus_access(16'hC010, 1'b0, 8'h00);
        flag_eq("read_key", read_key, 1'b1);
        bus_access(16'hC070, 1'b0, 8'h00);     // Paddle timers
        flag_eq("pdl_strobe", pdl_strobe, 1'b1);
        bus_access(16'hC040, 1'b0, 8'h00);
        flag_eq("stb", stb, 1'b1);
        gp_v = 8'(next_random() >> 24);
        bus_access(16'hC061, 1'b0, 8'h00);
        byte_eq("rdata", rdata, {gp_v[1], 7'b0});
        k_v = 8'(next_random() >> 24);
        bus_access(16'hC000, 1'b0, 8'h00);
        byte_eq("rdata", rdata, k_v);
    endtask

    task automatic back_to_back();
        logic [15:0] a [3];
        int          n;
        int          i;
        for (i = 0; i < 3; i++)
            a[i] = 16'((next_random() >> 8) % 32'hC000);
        for (i = 0; i < 3; i++)
        begin
            @(posedge CLK_14M);
            bus_strobe <= 1'b1;
            addr       <= a[i];
            we         <= 1'b0;
        end
        @(posedge CLK_14M);
        bus_strobe <= 1'b0;
        n = 0;
        for (i = 0; i < RSP_WAIT; i++)
        begin
            @(negedge CLK_14M);
            if (rsp_valid)
            begin
                if (n < 3)
                    ram_addr_eq("ram_addr", ram_addr, a[n]);
                if (i != n)
                begin
                    errors++;
                    $display("%0t ns: response %0d came out of step", $time, n);
                end
                n++;
            end
        end
        if (n != 3)
        begin
            errors++;
            $display("%0t ns: %0d responses for 3 strobes", $time, n);
        end
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------

    initial
    begin
        reset      = 1'b1;
        bus_strobe = 1'b0;
        addr       = '0;
        we         = 1'b0;
        wdata      = '0;
        ram_do     = '0;
        k          = '0;
        akd        = 1'b0;
        gameport   = '0;
        pd         = '0;
        repeat (2) @(posedge CLK_14M);
        reset <= 1'b0;

        mark = errors;
        region_decode();
        report_test("region decode", mark);
        mark = errors;
        aux_switches();
        report_test("aux switches", mark);
        mark = errors;
        display_switches();
        report_test("display switches", mark);
        mark = errors;
        language_card();
        report_test("language card", mark);
        mark = errors;
        slot_space();
        report_test("slot space", mark);
        mark = errors;
        back_to_back();
        report_test("back to back", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(RUN_LIMIT);
        $display("Watchdog expired after %0d ns, run did not finish", RUN_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
a2bus_pkg.sv
a2bus_decode.sv
a2bus_switches.sv
a2bus_mapper.sv
a2bus_top.sv
a2bus_assert.sv
tb_a2bus.sv

// ==== Bender.yml ====
package:
  name: a2bus

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - a2bus_pkg.sv
      - a2bus_decode.sv
      - a2bus_switches.sv
      - a2bus_mapper.sv
      - a2bus_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - a2bus_assert.sv
      - tb_a2bus.sv
